//--- all.f
epoch_vdp_pkg.sv
vdp_reg_bus_if.sv
cpu_bus_port.sv
ctrl_reg_bank.sv
raster_timing.sv
video_out.sv
epoch_vdp_top.sv
epoch_vdp_sva.sv
tb_checker.sv
tb_top.sv

//--- tb_top.sv
// Testbench top with a 20x24 raster, a table of CPU accesses and video checks
// CE is held high and CP1_POSEDGE pulses every fourth clock

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_rows = 20;
  localparam int num_cols = 24;
  localparam int first_row_render = 2;
  localparam int last_row_render = 15;
  localparam int first_col_render = 3;
  localparam int last_col_render = 18;
  localparam int first_row_vsync = 17;
  localparam int last_row_vsync = 18;
  localparam int first_col_hsync = 20;
  localparam int last_col_hsync = 22;
  localparam int read_ticks = 2;
  localparam int write_ticks = 1;

  localparam int hs_per_frame = num_rows * (last_col_hsync - first_col_hsync + 1);
  localparam int vs_per_frame = num_cols * (last_row_vsync - first_row_vsync + 1);
  localparam int de_per_frame = (last_row_render - first_row_render + 1) *
                                (last_col_render - first_col_render + 1);
  localparam int vbl_per_frame = (num_rows - (last_row_render - first_row_render + 1)) *
                                 num_cols;

  // Palette entries used by the colour tests as {R, G, B}
  localparam logic [23:0] rgb_code0 = {8'd0, 8'd0, 8'd160};
  localparam logic [23:0] rgb_code5 = {8'd150, 8'd235, 8'd150};
  localparam logic [23:0] rgb_code8 = {8'd245, 8'd0, 8'd0};

  typedef enum logic [2:0] {op_sync, op_write, op_read, op_rgb, op_count} op_t;

  typedef struct packed {
    op_t         op;
    logic [12:0] addr;
    logic [7:0]  data;
    logic [31:0] expected;
  } step_t;

  logic        CLK;
  logic        cpu_wait_cnt_resetting;
  logic        CE;
  logic        CP1_POSEDGE = 1'b0;
  logic [12:0] A;
  logic [7:0]  DB_I;
  logic        RDB;
  logic        WRB;
  logic        CSB;
  logic [7:0]  DB_O;
  logic        DB_OE;
  logic        WAITB;
  logic        VBL;
  logic        DE;
  logic        HS;
  logic        VS;
  logic [23:0] RGB;
  logic [1:0]  cp1_div = 2'd0;

  step_t       steps[$];
  integer      seed;
  logic [7:0]  rnd_window;
  logic [7:0]  rnd_junk;

  epoch_vdp_top #(
    .num_rows (num_rows), .num_cols (num_cols),
    .first_row_render (first_row_render), .last_row_render (last_row_render),
    .first_col_render (first_col_render), .last_col_render (last_col_render),
    .first_row_vsync (first_row_vsync), .last_row_vsync (last_row_vsync),
    .first_col_hsync (first_col_hsync), .last_col_hsync (last_col_hsync)
  ) epoch_vdp_top_inst (
    .CLK (CLK), .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting), .CE (CE),
    .CP1_POSEDGE (CP1_POSEDGE), .A (A), .DB_I (DB_I), .RDB (RDB), .WRB (WRB),
    .CSB (CSB), .DB_O (DB_O), .DB_OE (DB_OE), .WAITB (WAITB), .VBL (VBL),
    .DE (DE), .HS (HS), .VS (VS), .RGB (RGB)
  );

  tb_checker #(.frame_cycles (num_rows * num_cols)) tb_checker_inst (
    .CLK (CLK), .DB_O (DB_O), .DB_OE (DB_OE), .WAITB (WAITB),
    .CP1_POSEDGE (CP1_POSEDGE), .HS (HS), .VS (VS), .VBL (VBL), .DE (DE),
    .RGB (RGB)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // CP1 tick every fourth clock
  always @(posedge CLK) begin
    cp1_div <= cp1_div + 1'b1;
    CP1_POSEDGE <= (cp1_div == 2'd3);
  end

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  function automatic void add_step(input op_t op, input logic [12:0] addr,
                                   input logic [7:0] data, input logic [31:0] expected);
    steps.push_back(step_t'({op, addr, data, expected}));
  endfunction

  function automatic void load_steps();
    add_step(op_sync, 13'h0000, 8'h00, 24'h0);
    add_step(op_rgb, 13'h0000, 8'h00, rgb_code0);
    add_step(op_write, 13'h1400, 8'h00, 24'h0);
    add_step(op_write, 13'h1401, 8'hA5, 24'h0);
    add_step(op_write, 13'h1402, rnd_window, 24'h0);
    add_step(op_write, 13'h1403, 8'h38, 24'h0);
    add_step(op_read, 13'h1400, 8'h00, 24'h00);
    add_step(op_read, 13'h1401, 8'h00, 24'hA5);
    add_step(op_read, 13'h1402, 8'h00, 24'(rnd_window));
    add_step(op_read, 13'h1403, 8'h00, 24'h38);
    // Still the reset colour until the frame boundary
    add_step(op_rgb, 13'h0000, 8'h00, rgb_code0);
    add_step(op_sync, 13'h0000, 8'h00, 24'h0);
    add_step(op_rgb, 13'h0000, 8'h00, rgb_code8);
    add_step(op_write, 13'h1400, 8'h01, 24'h0);
    add_step(op_rgb, 13'h0000, 8'h00, rgb_code8);
    add_step(op_sync, 13'h0000, 8'h00, 24'h0);
    add_step(op_rgb, 13'h0000, 8'h00, rgb_code5);
    // Unmapped space
    add_step(op_read, 13'h0000, 8'h00, 24'hFF);
    add_step(op_write, 13'h1600, rnd_junk, 24'h0);
    add_step(op_read, 13'h1400, 8'h00, 24'h01);
    add_step(op_read, 13'h1401, 8'h00, 24'hA5);
    add_step(op_read, 13'h1402, 8'h00, 24'(rnd_window));
    add_step(op_read, 13'h1403, 8'h00, 24'h38);
    add_step(op_count, 13'h0000, 8'h00,
             {8'(hs_per_frame), 8'(vs_per_frame), 8'(de_per_frame), 8'(vbl_per_frame)});
  endfunction

  task automatic cpu_access(input int idx, input bit is_read, input logic [12:0] addr,
                            input logic [7:0] data, input logic [7:0] exp_data);
    @(posedge CLK);
    A <= addr;
    DB_I <= data;
    CSB <= 1'b0;
    RDB <= ~is_read;
    WRB <= is_read;
    tb_checker_inst.check_access(idx, is_read, addr,
                                 is_read ? read_ticks : write_ticks, exp_data);
    @(posedge CLK);
    CSB <= 1'b1;
    RDB <= 1'b1;
    WRB <= 1'b1;
    @(posedge CLK);
  endtask

  task automatic run_step(input int idx);
    step_t s;
    s = steps[idx];
    case (s.op)
      op_sync: tb_checker_inst.wait_frame_start();
      op_write: cpu_access(idx, 1'b0, s.addr, s.data, s.expected[7:0]);
      op_read: cpu_access(idx, 1'b1, s.addr, s.data, s.expected[7:0]);
      op_rgb: tb_checker_inst.check_rgb(idx, s.expected[23:0]);
      default: tb_checker_inst.count_frame(idx, s.expected[31:24], s.expected[23:16],
                                           s.expected[15:8], s.expected[7:0]);
    endcase
  endtask

  initial begin : stimulus
    cpu_wait_cnt_resetting = 1'b1;
    CE = 1'b1;
    A = '0;
    DB_I = '0;
    RDB = 1'b1;
    WRB = 1'b1;
    CSB = 1'b1;
    seed = 89162;
    rnd_window = 8'($random(seed));
    rnd_junk = 8'($random(seed));
    load_steps();
    repeat (3) @(posedge CLK);
    cpu_wait_cnt_resetting <= 1'b0;
    foreach (steps[i]) begin
      if (!tb_checker_inst.timed_out) begin
        run_step(i);
      end
    end
    $display("Tests run: %0d, failed checks: %0d",
             tb_checker_inst.test_count, tb_checker_inst.error_count);
    if (tb_checker_inst.error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- tb_checker.sv
// Testbench checker sampling DUT outputs on the falling clock edge
// Each wait gives up after a bounded number of clocks and flags a timeout

module tb_checker #(
  parameter int frame_cycles = 480
) (
  input logic        CLK,
  input logic [7:0]  DB_O,
  input logic        DB_OE,
  input logic        WAITB,
  input logic        CP1_POSEDGE,
  input logic        HS,
  input logic        VS,
  input logic        VBL,
  input logic        DE,
  input logic [23:0] RGB
);
  timeunit 1ns;
  timeprecision 1ps;

  int error_count = 0;
  int test_count = 0;
  bit timed_out = 1'b0;

  function automatic bit compare(input string name, input logic [23:0] exp,
                                 input logic [23:0] act);
    if (act !== exp) begin
      $display("MISMATCH at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
      error_count++;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic finish_test(input int idx, input string what, input bit ok);
    test_count++;
    $display("test %0d %s: %s", idx, what, ok ? "pass" : "FAIL");
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout: %s", what);
    timed_out = 1'b1;
    error_count++;
  endtask

  ////////////////////////////////////////
  // CPU access
  ////////////////////////////////////////

  task automatic check_access(input int idx, input bit is_read, input logic [12:0] addr,
                              input int exp_ticks, input logic [7:0] exp_data);
    int n;
    int ticks;
    bit ok;
    n = 0;
    ticks = 0;
    @(negedge CLK);
    while (WAITB !== 1'b0 && n < 40) begin
      @(negedge CLK);
      n++;
    end
    if (WAITB !== 1'b0) begin
      note_timeout("WAITB never went low during the CPU access");
      return;
    end
    // Values seen here are the ones the DUT takes at the next rising edge
    n = 0;
    while (WAITB === 1'b0 && n < 40) begin
      if (CP1_POSEDGE === 1'b1) begin
        ticks++;
      end
      @(negedge CLK);
      n++;
    end
    if (WAITB !== 1'b1) begin
      note_timeout("WAITB stayed low after the CPU access");
      return;
    end
    ok = compare("WAITB low ticks", 24'(exp_ticks), 24'(ticks));
    ok &= compare("DB_OE", 24'(is_read), 24'(DB_OE));
    if (is_read) begin
      ok &= compare("DB_O", 24'(exp_data), 24'(DB_O));
    end
    finish_test(idx, $sformatf("%s $%h", is_read ? "read" : "write", addr), ok);
  endtask

  ////////////////////////////////////////
  // Video
  ////////////////////////////////////////

  task automatic wait_frame_start();
    int n;
    logic vs_prev;
    n = 0;
    vs_prev = 1'b1;
    @(negedge CLK);
    while (!(VS === 1'b1 && vs_prev === 1'b0) && n < 2 * frame_cycles) begin
      vs_prev = VS;
      @(negedge CLK);
      n++;
    end
    if (!(VS === 1'b1 && vs_prev === 1'b0)) begin
      note_timeout("no start of vertical sync within two frames");
    end
  endtask

  task automatic wait_for_de(input logic level, output bit found);
    int n;
    n = 0;
    @(negedge CLK);
    while (DE !== level && n < frame_cycles) begin
      @(negedge CLK);
      n++;
    end
    found = (DE === level);
    if (!found) begin
      note_timeout($sformatf("DE did not reach %b within one frame", level));
    end
  endtask

  task automatic check_rgb(input int idx, input logic [23:0] exp_in);
    bit found;
    bit ok;
    wait_for_de(1'b1, found);
    if (!found) begin
      return;
    end
    ok = compare("RGB in window", exp_in, RGB);
    wait_for_de(1'b0, found);
    if (!found) begin
      return;
    end
    // Black outside the render window
    ok &= compare("RGB outside window", 24'h000000, RGB);
    finish_test(idx, $sformatf("background %h", exp_in), ok);
  endtask

  task automatic count_frame(input int idx, input int exp_hs, input int exp_vs,
                             input int exp_de, input int exp_vbl);
    int hs_cnt;
    int vs_cnt;
    int de_cnt;
    int vbl_cnt;
    bit ok;
    hs_cnt = 0;
    vs_cnt = 0;
    de_cnt = 0;
    vbl_cnt = 0;
    wait_frame_start();
    if (timed_out) begin
      return;
    end
    for (int i = 0; i < frame_cycles; i++) begin
      if (i > 0) begin
        @(negedge CLK);
      end
      hs_cnt += (HS === 1'b1);
      vs_cnt += (VS === 1'b1);
      de_cnt += (DE === 1'b1);
      vbl_cnt += (VBL === 1'b1);
    end
    ok = compare("HS cycles", 24'(exp_hs), 24'(hs_cnt));
    ok &= compare("VS cycles", 24'(exp_vs), 24'(vs_cnt));
    ok &= compare("DE cycles", 24'(exp_de), 24'(de_cnt));
    ok &= compare("VBL cycles", 24'(exp_vbl), 24'(vbl_cnt));
    finish_test(idx, "sync counts over one frame", ok);
  endtask

endmodule

//--- epoch_vdp_sva.sv
// Assertions bound to epoch_vdp_top
// The WAITB limit assumes CP1_POSEDGE is high for one clock per tick

module epoch_vdp_sva (
  input logic CLK,
  input logic cpu_wait_cnt_resetting,
  input logic CP1_POSEDGE,
  input logic DB_OE,
  input logic WAITB,
  input logic HS,
  input logic VS,
  input logic DE
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [2:0] low_ticks;

  // CP1 ticks so far in the current WAITB low period
  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting || WAITB) begin
      low_ticks <= '0;
    end else if (CP1_POSEDGE) begin
      low_ticks <= low_ticks + 1'b1;
    end
  end

  oe_quiet_in_reset: assert property (
    @(posedge CLK) cpu_wait_cnt_resetting |-> !$rose(DB_OE)
  ) else $error("DB_OE rose while reset was asserted");

  no_sync_in_window: assert property (
    @(posedge CLK) disable iff (cpu_wait_cnt_resetting) DE |-> !(HS || VS)
  ) else $error("HS or VS high inside the render window");

  // Fourth tick with WAITB still low is too late
  waitb_released: assert property (
    @(posedge CLK) disable iff (cpu_wait_cnt_resetting)
      (!WAITB && CP1_POSEDGE) |-> (low_ticks < 3'd3)
  ) else $error("WAITB held low for more than 3 CP1 ticks");

endmodule

bind epoch_vdp_top epoch_vdp_sva epoch_vdp_sva_inst (
  .CLK                    (CLK),
  .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
  .CP1_POSEDGE            (CP1_POSEDGE),
  .DB_OE                  (DB_OE),
  .WAITB                  (WAITB),
  .HS                     (HS),
  .VS                     (VS),
  .DE                     (DE)
);

//--- epoch_vdp_top.sv
// TV-1 video core top: CPU bus port, control registers and background video
// Raster defaults are the hardware timing; smaller rasters are set here

module epoch_vdp_top import epoch_vdp_pkg::*; #(
  parameter raster_pos_t num_rows = 9'd263,
  parameter raster_pos_t num_cols = 9'd260,
  parameter raster_pos_t first_row_render = 9'd16,
  parameter raster_pos_t last_row_render = 9'd247,
  parameter raster_pos_t first_col_render = 9'd23,
  parameter raster_pos_t last_col_render = 9'd230,
  parameter raster_pos_t first_row_vsync = 9'd257,
  parameter raster_pos_t last_row_vsync = 9'd259,
  parameter raster_pos_t first_col_hsync = 9'd240,
  parameter raster_pos_t last_col_hsync = 9'd259
) (
  input  logic      CLK,
  input  logic      cpu_wait_cnt_resetting,
  input  logic      CE,
  input  logic      CP1_POSEDGE,
  input  cpu_addr_t A,
  input  byte_t     DB_I,
  input  logic      RDB,
  input  logic      WRB,
  input  logic      CSB,
  output byte_t     DB_O,
  output logic      DB_OE,
  output logic      WAITB,
  output logic      VBL,
  output logic      DE,
  output logic      HS,
  output logic      VS,
  output rgb_t      RGB
);

  logic  frame_latch;
  byte_t active_mode;
  byte_t active_bm_color;
  byte_t active_ch_color;

  vdp_reg_bus_if reg_bus ();

  cpu_bus_port cpu_bus_port_inst (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .CP1_POSEDGE            (CP1_POSEDGE),
    .A                      (A),
    .DB_I                   (DB_I),
    .RDB                    (RDB),
    .WRB                    (WRB),
    .CSB                    (CSB),
    .DB_O                   (DB_O),
    .DB_OE                  (DB_OE),
    .WAITB                  (WAITB),
    .bus                    (reg_bus)
  );

  ctrl_reg_bank ctrl_reg_bank_inst (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .frame_latch            (frame_latch),
    .active_mode            (active_mode),
    .active_bm_color        (active_bm_color),
    .active_ch_color        (active_ch_color),
    .bus                    (reg_bus)
  );

  video_out #(
    .num_rows         (num_rows),
    .num_cols         (num_cols),
    .first_row_render (first_row_render),
    .last_row_render  (last_row_render),
    .first_col_render (first_col_render),
    .last_col_render  (last_col_render),
    .first_row_vsync  (first_row_vsync),
    .last_row_vsync   (last_row_vsync),
    .first_col_hsync  (first_col_hsync),
    .last_col_hsync   (last_col_hsync)
  ) video_out_inst (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .CE                     (CE),
    .active_mode            (active_mode),
    .active_bm_color        (active_bm_color),
    .active_ch_color        (active_ch_color),
    .frame_latch            (frame_latch),
    .HS                     (HS),
    .VS                     (VS),
    .VBL                    (VBL),
    .DE                     (DE),
    .RGB                    (RGB)
  );

endmodule

//--- video_out.sv
// Flat background colour per frame, black outside the render window
// RGB follows the registered window flag and so lines up with DE

module video_out import epoch_vdp_pkg::*; #(
  parameter raster_pos_t num_rows = 9'd263,
  parameter raster_pos_t num_cols = 9'd260,
  parameter raster_pos_t first_row_render = 9'd16,
  parameter raster_pos_t last_row_render = 9'd247,
  parameter raster_pos_t first_col_render = 9'd23,
  parameter raster_pos_t last_col_render = 9'd230,
  parameter raster_pos_t first_row_vsync = 9'd257,
  parameter raster_pos_t last_row_vsync = 9'd259,
  parameter raster_pos_t first_col_hsync = 9'd240,
  parameter raster_pos_t last_col_hsync = 9'd259
) (
  input  logic  CLK,
  input  logic  cpu_wait_cnt_resetting,
  input  logic  CE,
  input  byte_t active_mode,
  input  byte_t active_bm_color,
  input  byte_t active_ch_color,
  output logic  frame_latch,
  output logic  HS,
  output logic  VS,
  output logic  VBL,
  output logic  DE,
  output rgb_t  RGB
);

  logic        in_render;
  logic        bm_ena;
  color_code_t bm_clr_bg;
  color_code_t ch_clr_bg;
  color_code_t pix_code;

  raster_timing #(
    .num_rows         (num_rows),
    .num_cols         (num_cols),
    .first_row_render (first_row_render),
    .last_row_render  (last_row_render),
    .first_col_render (first_col_render),
    .last_col_render  (last_col_render),
    .first_row_vsync  (first_row_vsync),
    .last_row_vsync   (last_row_vsync),
    .first_col_hsync  (first_col_hsync),
    .last_col_hsync   (last_col_hsync)
  ) raster_timing_inst (
    .CLK                    (CLK),
    .cpu_wait_cnt_resetting (cpu_wait_cnt_resetting),
    .CE                     (CE),
    .frame_latch            (frame_latch),
    .in_render              (in_render),
    .HS                     (HS),
    .VS                     (VS),
    .VBL                    (VBL),
    .DE                     (DE)
  );

  ////////////////////////////////////////
  // Colour select
  ////////////////////////////////////////

  // Mode bit 0 picks bitmap over character background
  assign bm_ena = active_mode[0];
  assign bm_clr_bg = active_bm_color[3:0];
  assign ch_clr_bg = active_ch_color[3:0];

  always_comb begin
    pix_code = BLACK_CODE;
    if (in_render) begin
      pix_code = bm_ena ? bm_clr_bg : ch_clr_bg;
    end
  end

  // Palette lookup
  assign RGB = PALETTE_RGB[pix_code];

endmodule

//--- raster_timing.sv
// Row/column raster counter with sync and render-window flags
// Flags come out one CE after the position they describe

module raster_timing import epoch_vdp_pkg::*; #(
  parameter raster_pos_t num_rows = 9'd263,
  parameter raster_pos_t num_cols = 9'd260,
  parameter raster_pos_t first_row_render = 9'd16,
  parameter raster_pos_t last_row_render = 9'd247,
  parameter raster_pos_t first_col_render = 9'd23,
  parameter raster_pos_t last_col_render = 9'd230,
  parameter raster_pos_t first_row_vsync = 9'd257,
  parameter raster_pos_t last_row_vsync = 9'd259,
  parameter raster_pos_t first_col_hsync = 9'd240,
  parameter raster_pos_t last_col_hsync = 9'd259
) (
  input  logic CLK,
  input  logic cpu_wait_cnt_resetting,
  input  logic CE,
  output logic frame_latch,
  output logic in_render,
  output logic HS,
  output logic VS,
  output logic VBL,
  output logic DE
);

  raster_pos_t row;
  raster_pos_t col;
  logic        render_row;
  logic        render_col;
  logic        hs_q;
  logic        vs_q;
  logic        vbl_q;
  logic        render_q;

  ////////////////////////////////////////
  // Position counter
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      row <= '0;
      col <= '0;
    end else if (CE) begin
      if (col == num_cols - 1'b1) begin
        col <= '0;
        row <= (row == num_rows - 1'b1) ? raster_pos_t'(0) : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Start of vertical sync
  assign frame_latch = CE & (row == first_row_vsync) & (col == '0);

  ////////////////////////////////////////
  // Sync and window flags
  ////////////////////////////////////////

  assign render_row = (row >= first_row_render) & (row <= last_row_render);
  assign render_col = (col >= first_col_render) & (col <= last_col_render);

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      hs_q <= 1'b0;
      vs_q <= 1'b0;
      // Row 0 lies in blanking
      vbl_q <= 1'b1;
      render_q <= 1'b0;
    end else if (CE) begin
      hs_q <= (col >= first_col_hsync) & (col <= last_col_hsync);
      vs_q <= (row >= first_row_vsync) & (row <= last_row_vsync);
      vbl_q <= ~render_row;
      render_q <= render_row & render_col;
    end
  end

  assign HS = hs_q;
  assign VS = vs_q;
  assign VBL = vbl_q;
  assign DE = render_q;
  assign in_render = render_q;

endmodule

//--- ctrl_reg_bank.sv
// Four shadow control registers, copied to the active set on frame_latch
// Register 2 has no active copy

module ctrl_reg_bank import epoch_vdp_pkg::*; (
  input  logic         CLK,
  input  logic         cpu_wait_cnt_resetting,
  input  logic         frame_latch,
  output byte_t        active_mode,
  output byte_t        active_bm_color,
  output byte_t        active_ch_color,
  vdp_reg_bus_if.slave bus
);

  byte_t shadow [4];
  logic  ack_q;
  byte_t dat_r_q;
  logic  req;

  ////////////////////////////////////////
  // Wishbone slave
  ////////////////////////////////////////

  // New request, not yet answered
  assign req = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      for (int i = 0; i < 4; i++) begin
        shadow[i] <= '0;
      end
    end else if (req & bus.we) begin
      shadow[bus.adr] <= bus.dat_w;
    end
  end

  // Reads return the shadow copy
  always_ff @(posedge CLK) begin
    if (req) begin
      dat_r_q <= shadow[bus.adr];
    end
  end

  assign bus.ack = ack_q;
  assign bus.dat_r = dat_r_q;

  ////////////////////////////////////////
  // Active registers
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      active_mode <= '0;
      active_bm_color <= '0;
      active_ch_color <= '0;
    end else if (frame_latch) begin
      active_mode <= shadow[REG_MODE];
      active_bm_color <= shadow[REG_BM_COLOR];
      active_ch_color <= shadow[REG_CH_COLOR];
    end
  end

endmodule

//--- cpu_bus_port.sv
// CPU bus port: CP1-tick wait states on WAITB and register access over Wishbone
// A new access is taken only after the previous one has ended on CSB/RDB/WRB

module cpu_bus_port import epoch_vdp_pkg::*; (
  input  logic          CLK,
  input  logic          cpu_wait_cnt_resetting,
  input  logic          CP1_POSEDGE,
  input  cpu_addr_t     A,
  input  byte_t         DB_I,
  input  logic          RDB,
  input  logic          WRB,
  input  logic          CSB,
  output byte_t         DB_O,
  output logic          DB_OE,
  output logic          WAITB,
  vdp_reg_bus_if.master bus
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_WAIT,
    ST_HOLD
  } bus_state_t;

  bus_state_t state;
  wait_cnt_t  wait_cnt;
  logic       waitb_q;
  logic       is_read;
  logic       cpu_rd;
  logic       cpu_wr;
  logic       sel_reg;
  logic       start;
  logic       cyc_q;
  logic       we_q;
  reg_idx_t   adr_q;
  byte_t      dat_w_q;
  byte_t      db_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign cpu_rd = ~(CSB | RDB);
  assign cpu_wr = ~(CSB | WRB);
  assign sel_reg = (A[12:9] == REG_REGION_TAG);
  assign start = (state == ST_IDLE) & waitb_q & (cpu_rd | cpu_wr);

  ////////////////////////////////////////
  // Wait-state FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      state <= ST_IDLE;
      wait_cnt <= '0;
      waitb_q <= 1'b1;
      is_read <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ARMED;
            is_read <= cpu_rd;
          end
        end
        // Counter loads on the first CP1 tick after recognition
        ST_ARMED: begin
          if (CP1_POSEDGE) begin
            wait_cnt <= is_read ? READ_WAIT_TICKS : WRITE_WAIT_TICKS;
            waitb_q <= 1'b0;
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (CP1_POSEDGE) begin
            wait_cnt <= wait_cnt - 1'b1;
            // Release on the tick that brings the count to zero
            if (wait_cnt == wait_cnt_t'(1)) begin
              waitb_q <= 1'b1;
              state <= ST_HOLD;
            end
          end
        end
        // Same access still on the bus
        ST_HOLD: begin
          if (~(cpu_rd | cpu_wr)) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (cpu_wait_cnt_resetting) begin
      cyc_q <= 1'b0;
    end else if (start & sel_reg) begin
      cyc_q <= 1'b1;
    end else if (cyc_q & bus.ack) begin
      cyc_q <= 1'b0;
    end
  end

  // Held steady for the whole transfer
  always_ff @(posedge CLK) begin
    if (start) begin
      we_q <= ~cpu_rd;
      adr_q <= A[1:0];
      dat_w_q <= DB_I;
    end
  end

  assign bus.cyc = cyc_q;
  assign bus.stb = cyc_q;
  assign bus.we = we_q;
  assign bus.adr = adr_q;
  assign bus.dat_w = dat_w_q;

  // Read data ready well before WAITB releases
  always_ff @(posedge CLK) begin
    if (start & cpu_rd & ~sel_reg) begin
      db_q <= UNMAPPED_READ;
    end else if (cyc_q & bus.ack & ~we_q) begin
      db_q <= bus.dat_r;
    end
  end

  assign DB_O = db_q;
  assign DB_OE = cpu_rd;
  assign WAITB = waitb_q;

endmodule

//--- vdp_reg_bus_if.sv
// Wishbone classic link to the control registers, one transfer outstanding
// Clocked by the CLK of the connected modules

interface vdp_reg_bus_if import epoch_vdp_pkg::*; ();

  logic     cyc;
  logic     stb;
  logic     we;
  reg_idx_t adr;
  byte_t    dat_w;
  byte_t    dat_r;
  logic     ack;

  // Bus port side
  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output dat_w,
    input  dat_r,
    input  ack
  );

  // Register file side
  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  dat_w,
    output dat_r,
    output ack
  );

endinterface

//--- epoch_vdp_pkg.sv
// Shared widths, register map and RGB palette for the TV-1 background core
// Palette holds the RGB connector levels only

package epoch_vdp_pkg;

  ////////////////////////////////////////
  // Bus and pixel types
  ////////////////////////////////////////

  typedef logic [12:0] cpu_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [1:0]  reg_idx_t;
  typedef logic [3:0]  color_code_t;
  // Packed as {R, G, B}
  typedef logic [23:0] rgb_t;
  typedef logic [8:0]  raster_pos_t;
  typedef logic [2:0]  wait_cnt_t;

  ////////////////////////////////////////
  // CPU bus decode
  ////////////////////////////////////////

  // A[12:9] for $1400-$15FF
  localparam logic [3:0] REG_REGION_TAG = 4'b1010;
  localparam byte_t UNMAPPED_READ = 8'hFF;

  // CP1 ticks of WAITB low per access type
  localparam wait_cnt_t READ_WAIT_TICKS = 3'd2;
  localparam wait_cnt_t WRITE_WAIT_TICKS = 3'd1;

  // Control register indices
  localparam reg_idx_t REG_MODE = 2'd0;
  localparam reg_idx_t REG_BM_COLOR = 2'd1;
  localparam reg_idx_t REG_WINDOW = 2'd2;
  localparam reg_idx_t REG_CH_COLOR = 2'd3;

  ////////////////////////////////////////
  // Colour
  ////////////////////////////////////////

  // Shown outside the render window
  localparam color_code_t BLACK_CODE = 4'd1;

  localparam rgb_t PALETTE_RGB [16] = '{
    {8'd0,   8'd0,   8'd160},
    {8'd0,   8'd0,   8'd0},
    {8'd0,   8'd0,   8'd245},
    {8'd160, 8'd0,   8'd235},
    {8'd0,   8'd245, 8'd0},
    {8'd150, 8'd235, 8'd150},
    {8'd0,   8'd235, 8'd235},
    {8'd0,   8'd160, 8'd0},
    {8'd245, 8'd0,   8'd0},
    {8'd235, 8'd160, 8'd0},
    {8'd235, 8'd0,   8'd235},
    {8'd235, 8'd150, 8'd150},
    {8'd235, 8'd235, 8'd0},
    {8'd160, 8'd160, 8'd0},
    {8'd150, 8'd150, 8'd150},
    {8'd225, 8'd225, 8'd225}
  };

endpackage
